/* clint/clint_regs.sv */
// ----------------------------------------------------------------------
// CLINT register block for a single hart
// mtime is read-only here, the timer owns it
// MIP is a read-only view of the interrupt-pending word
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "soc_periph_defs.svh"

module clint_regs
  import soc_bus_pkg::*;
  import soc_irq_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        sel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  apb_addr_t   paddr_i,
  input  apb_data_t   pwdata_i,
  output apb_data_t   rdata_o,
  output logic        err_o,
  input  logic [63:0] mtime_i,
  input  logic        mtip_i,
  input  logic [1:0]  irq_ext_i,
  output logic [63:0] mtimecmp_o,
  output logic        ipi_o,
  output irq_word_u   irq_vec_o
);

  logic [15:0] offset;
  logic        access;
  logic        we;
  logic        unknown;
  logic        read_only;
  logic        msip_q;
  logic [63:0] mtimecmp_q;

  assign offset = paddr_i[15:0];
  assign access = sel_i & penable_i;
  assign we     = access & pwrite_i;

  // --------------------------------------------------------------------
  // register writes
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
    end else if (we) begin
      case (offset)
        `MSIP_OFS:        msip_q             <= pwdata_i[0];
        `MTIMECMP_LO_OFS: mtimecmp_q[31:0]  <= pwdata_i;
        `MTIMECMP_HI_OFS: mtimecmp_q[63:32] <= pwdata_i;
        default: ;
      endcase
    end
  end

  // --------------------------------------------------------------------
  // read mux and illegal access flags
  // --------------------------------------------------------------------
  always_comb begin
    rdata_o   = '0;
    unknown   = 1'b0;
    read_only = 1'b0;
    case (offset)
      `MSIP_OFS:        rdata_o = {31'b0, msip_q};
      `MIP_OFS: begin
        rdata_o   = irq_vec_o.raw;
        read_only = 1'b1;
      end
      `MTIMECMP_LO_OFS: rdata_o = mtimecmp_q[31:0];
      `MTIMECMP_HI_OFS: rdata_o = mtimecmp_q[63:32];
      `MTIME_LO_OFS: begin
        rdata_o   = mtime_i[31:0];
        read_only = 1'b1;
      end
      `MTIME_HI_OFS: begin
        rdata_o   = mtime_i[63:32];
        read_only = 1'b1;
      end
      default: unknown = 1'b1;
    endcase
  end

  assign err_o = access & (unknown | (pwrite_i & read_only));

  // pending word, meip on ext bit 0 and seip on ext bit 1
  always_comb begin
    irq_vec_o             = '0;
    irq_vec_o.fields.msip = msip_q;
    irq_vec_o.fields.mtip = mtip_i;
    irq_vec_o.fields.seip = irq_ext_i[1];
    irq_vec_o.fields.meip = irq_ext_i[0];
  end

  assign mtimecmp_o = mtimecmp_q;
  assign ipi_o      = msip_q;

endmodule

/* clint/clint_timer.sv */
// ----------------------------------------------------------------------
// mtime counter driven by rising edges of the asynchronous rtc_i
// rtc_i must stay high and low for at least two clk_i cycles each
// mtip is registered, one cycle behind the compare
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module clint_timer (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rtc_i,
  input  logic [63:0] mtimecmp_i,
  output logic [63:0] mtime_o,
  output logic        mtip_o
);

  logic [1:0]  rtc_sync_q;
  logic        rtc_prev_q;
  logic        rtc_rise;
  logic [63:0] mtime_q;
  logic        mtip_q;

  // --------------------------------------------------------------------
  // rtc synchronizer and edge detect
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  // --------------------------------------------------------------------
  // counter and compare
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q <= '0;
      mtip_q  <= 1'b0;
    end else begin
      if (rtc_rise) begin
        mtime_q <= mtime_q + 64'd1;
      end
      // unsigned 64-bit compare
      mtip_q <= (mtime_q >= mtimecmp_i);
    end
  end

  assign mtime_o = mtime_q;
  assign mtip_o  = mtip_q;

endmodule

/* common/soc_bus_pkg.sv */
// ----------------------------------------------------------------------
// APB payload types and the decoder region encoding
// strobes cover one 32-bit data word, one bit per byte
// ----------------------------------------------------------------------

`include "soc_periph_defs.svh"

package soc_bus_pkg;

  typedef logic [`APB_ADDR_W-1:0]   apb_addr_t;
  typedef logic [`APB_DATA_W-1:0]   apb_data_t;
  typedef logic [`APB_DATA_W/8-1:0] apb_strb_t;

  // target of the current transfer, NONE is the error region
  typedef enum logic [1:0] {
    REGION_NONE  = 2'd0,
    REGION_ROM   = 2'd1,
    REGION_SRAM  = 2'd2,
    REGION_CLINT = 2'd3
  } region_e;

endpackage

/* common/soc_irq_pkg.sv */
// ----------------------------------------------------------------------
// machine interrupt-pending word in the privileged-spec bit layout
// only msip, mtip, seip and meip exist, all other bits read zero
// ----------------------------------------------------------------------

package soc_irq_pkg;

  import soc_bus_pkg::*;

  // mip layout, bit 0 at the bottom
  typedef struct packed {
    logic [19:0] rsvd_31_12;
    logic        meip;
    logic        rsvd_10;
    logic        seip;
    logic        rsvd_8;
    logic        mtip;
    logic [2:0]  rsvd_6_4;
    logic        msip;
    logic [2:0]  rsvd_2_0;
  } irq_fields_t;

  // same word, seen raw on the bus or by fields in the CLINT
  typedef union packed {
    apb_data_t   raw;
    irq_fields_t fields;
  } irq_word_u;

endpackage

/* common/soc_periph_defs.svh */
// ----------------------------------------------------------------------
// widths, memory map and CLINT offsets of the peripheral subsystem
// region windows must not overlap, the decoder checks them in order
// CLINT offsets are taken on the low 16 address bits only
// ----------------------------------------------------------------------

`ifndef SOC_PERIPH_DEFS_SVH
`define SOC_PERIPH_DEFS_SVH

// bus widths
`define APB_ADDR_W 32
`define APB_DATA_W 32

// memory map
`define ROM_BASE   32'h0000_1000
`define ROM_SIZE   32'h0000_0040
`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000
`define SRAM_BASE  32'h8000_0000
`define SRAM_WORDS 256

// CLINT register offsets
`define MSIP_OFS        16'h0000
`define MIP_OFS         16'h0008
`define MTIMECMP_LO_OFS 16'h4000
`define MTIMECMP_HI_OFS 16'h4004
`define MTIME_LO_OFS    16'hBFF8
`define MTIME_HI_OFS    16'hBFFC

// upper half of every boot ROM word
`define ROM_SIGNATURE 16'hb007

`endif

/* hdl/apb_decoder.sv */
// ----------------------------------------------------------------------
// address decode into ROM, SRAM and CLINT windows
// anything outside them hits the error region, which answers
// with pslverr and zero data in the first access cycle
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "soc_periph_defs.svh"

module apb_decoder
  import soc_bus_pkg::*;
(
  input  logic      psel_i,
  input  logic      penable_i,
  input  apb_addr_t paddr_i,
  output apb_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  output logic      rom_sel_o,
  output logic      sram_sel_o,
  output logic      clint_sel_o,
  input  apb_data_t rom_rdata_i,
  input  apb_data_t sram_rdata_i,
  input  apb_data_t clint_rdata_i,
  input  logic      rom_err_i,
  input  logic      clint_err_i,
  input  logic      sram_ready_i
);

  region_e region;

  // base inclusive, base + size exclusive
  function automatic logic in_window(apb_addr_t addr, apb_addr_t base, apb_addr_t size);
    in_window = (addr >= base) && ((addr - base) < size);
  endfunction

  // --------------------------------------------------------------------
  // region select
  // --------------------------------------------------------------------
  always_comb begin
    if (in_window(paddr_i, `ROM_BASE, `ROM_SIZE)) begin
      region = REGION_ROM;
    end else if (in_window(paddr_i, `SRAM_BASE, apb_addr_t'(`SRAM_WORDS * 4))) begin
      region = REGION_SRAM;
    end else if (in_window(paddr_i, `CLINT_BASE, `CLINT_SIZE)) begin
      region = REGION_CLINT;
    end else begin
      region = REGION_NONE;
    end
  end

  // --------------------------------------------------------------------
  // selects and response mux
  // --------------------------------------------------------------------
  always_comb begin
    rom_sel_o   = 1'b0;
    sram_sel_o  = 1'b0;
    clint_sel_o = 1'b0;
    prdata_o    = '0;
    // only the SRAM can stall
    pready_o    = 1'b1;
    pslverr_o   = 1'b0;
    case (region)
      REGION_ROM: begin
        rom_sel_o = psel_i;
        prdata_o  = rom_rdata_i;
        pslverr_o = rom_err_i;
      end
      REGION_SRAM: begin
        sram_sel_o = psel_i;
        prdata_o   = sram_rdata_i;
        pready_o   = sram_ready_i;
      end
      REGION_CLINT: begin
        clint_sel_o = psel_i;
        prdata_o    = clint_rdata_i;
        pslverr_o   = clint_err_i;
      end
      default: begin
        // error region, stands in for the missing GPIO block
        pslverr_o = psel_i & penable_i;
      end
    endcase
  end

endmodule

/* hdl/apb_sram.sv */
// ----------------------------------------------------------------------
// 256-word SRAM, byte strobes on write
// writes finish in the first access cycle, reads take one wait state
// contents are undefined after reset
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "soc_periph_defs.svh"

module apb_sram
  import soc_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      sel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  input  apb_strb_t pstrb_i,
  output apb_data_t rdata_o,
  output logic      ready_o
);

  localparam int IdxW = $clog2(`SRAM_WORDS);

  apb_data_t       mem [`SRAM_WORDS];
  apb_data_t       rdata_q;
  logic            wait_q;
  logic [IdxW-1:0] idx;
  logic            wr_en;
  logic            rd_en;

  assign idx   = paddr_i[IdxW+1:2];
  assign wr_en = sel_i & penable_i & pwrite_i;
  // first access cycle of a read only
  assign rd_en = sel_i & penable_i & ~pwrite_i & ~wait_q;

  // storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < `APB_DATA_W / 8; b++) begin
        if (pstrb_i[b]) begin
          mem[idx][8*b +: 8] <= pwdata_i[8*b +: 8];
        end
      end
    end
    if (rd_en) begin
      rdata_q <= mem[idx];
    end
  end

  // wait flag, set for exactly one cycle per read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= rd_en;
    end
  end

  assign rdata_o = rdata_q;
  assign ready_o = pwrite_i | wait_q;

endmodule

/* hdl/boot_rom.sv */
// ----------------------------------------------------------------------
// sixteen-word boot ROM, word i = {signature, i}
// address bits above 5 are ignored inside the window
// writes are refused with an error
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "soc_periph_defs.svh"

module boot_rom
  import soc_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      sel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  output apb_data_t rdata_o,
  output logic      err_o
);

  apb_data_t rom_word;
  apb_data_t rdata_q;

  // table contents
  always_comb begin
    rom_word = {`ROM_SIGNATURE, 12'h000, paddr_i[5:2]};
  end

  // word captured in setup, stable for the whole access phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (sel_i && !penable_i && !pwrite_i) begin
      rdata_q <= rom_word;
    end
  end

  assign rdata_o = rdata_q;

  // read-only
  assign err_o = sel_i & penable_i & pwrite_i;

endmodule

/* hdl/soc_periph_top.sv */
// ----------------------------------------------------------------------
// APB peripheral subsystem: boot ROM, SRAM, CLINT and error region
// one transfer in flight, master holds signals until pready
// rtc_i is asynchronous and is synchronized inside the CLINT timer
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module soc_periph_top
  import soc_bus_pkg::*;
  import soc_irq_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  input  apb_strb_t pstrb_i,
  output apb_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o,
  input  logic      rtc_i,
  input  logic [1:0] irq_ext_i,
  output logic      timer_irq_o,
  output logic      ipi_o,
  output irq_word_u irq_vec_o
);

  logic        rom_sel, sram_sel, clint_sel;
  apb_data_t   rom_rdata, sram_rdata, clint_rdata;
  logic        rom_err, clint_err, sram_ready;
  logic [63:0] mtime, mtimecmp;

  apb_decoder apb_decoder_inst (
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .paddr_i       ( paddr_i     ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   ),
    .rom_sel_o     ( rom_sel     ),
    .sram_sel_o    ( sram_sel    ),
    .clint_sel_o   ( clint_sel   ),
    .rom_rdata_i   ( rom_rdata   ),
    .sram_rdata_i  ( sram_rdata  ),
    .clint_rdata_i ( clint_rdata ),
    .rom_err_i     ( rom_err     ),
    .clint_err_i   ( clint_err   ),
    .sram_ready_i  ( sram_ready  )
  );

  boot_rom boot_rom_inst (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .sel_i     ( rom_sel   ),
    .penable_i ( penable_i ),
    .pwrite_i  ( pwrite_i  ),
    .paddr_i   ( paddr_i   ),
    .rdata_o   ( rom_rdata ),
    .err_o     ( rom_err   )
  );

  apb_sram apb_sram_inst (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .sel_i     ( sram_sel   ),
    .penable_i ( penable_i  ),
    .pwrite_i  ( pwrite_i   ),
    .paddr_i   ( paddr_i    ),
    .pwdata_i  ( pwdata_i   ),
    .pstrb_i   ( pstrb_i    ),
    .rdata_o   ( sram_rdata ),
    .ready_o   ( sram_ready )
  );

  // CLINT register block and the timer it steers
  clint_regs clint_regs_inst (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .sel_i      ( clint_sel   ),
    .penable_i  ( penable_i   ),
    .pwrite_i   ( pwrite_i    ),
    .paddr_i    ( paddr_i     ),
    .pwdata_i   ( pwdata_i    ),
    .rdata_o    ( clint_rdata ),
    .err_o      ( clint_err   ),
    .mtime_i    ( mtime       ),
    .mtip_i     ( timer_irq_o ),
    .irq_ext_i  ( irq_ext_i   ),
    .mtimecmp_o ( mtimecmp    ),
    .ipi_o      ( ipi_o       ),
    .irq_vec_o  ( irq_vec_o   )
  );

  clint_timer clint_timer_inst (
    .clk_i      ( clk_i       ),
    .rst_ni     ( rst_ni      ),
    .rtc_i      ( rtc_i       ),
    .mtimecmp_i ( mtimecmp    ),
    .mtime_o    ( mtime       ),
    .mtip_o     ( timer_irq_o )
  );

endmodule

/* soc_periph.f */
+incdir+common
common/soc_bus_pkg.sv
common/soc_irq_pkg.sv
hdl/apb_decoder.sv
hdl/boot_rom.sv
hdl/apb_sram.sv
clint/clint_regs.sv
clint/clint_timer.sv
hdl/soc_periph_top.sv
tests/soc_periph_assertions.sv
tests/soc_periph_tb.sv

/* tests/soc_periph_assertions.sv */
// ----------------------------------------------------------------------
// APB and interrupt checks, bound into soc_periph_top
// failures are counted so the testbench can see them at the end
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module soc_periph_assertions
  import soc_bus_pkg::*;
  import soc_irq_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      psel_i,
  input logic      penable_i,
  input logic      pwrite_i,
  input apb_data_t prdata_i,
  input logic      pready_i,
  input logic      pslverr_i,
  input logic      ipi_i,
  input logic      timer_irq_i
);

  int unsigned fail_count = 0;

  // --------------------------------------------------------------------
  // APB protocol
  // --------------------------------------------------------------------
  err_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pslverr_i |-> pready_i)
    else begin
      $error("pslverr high without pready");
      fail_count++;
    end

  enable_needs_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_i |-> psel_i)
    else begin
      $error("penable high without psel");
      fail_count++;
    end

  // read data must be known on the completing edge
  rdata_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (psel_i && penable_i && pready_i && !pwrite_i) |-> !$isunknown(prdata_i))
    else begin
      $error("prdata unknown on read completion");
      fail_count++;
    end

  // --------------------------------------------------------------------
  // interrupts
  // --------------------------------------------------------------------
  irq_low_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!ipi_i && !timer_irq_i))
    else begin
      $error("interrupt output high right after reset release");
      fail_count++;
    end

endmodule

/* tests/soc_periph_tb.sv */
// ----------------------------------------------------------------------
// testbench for the APB peripheral subsystem
// covers ROM, SRAM, error region, software and timer interrupts
// stops at the first mismatch, every wait has its own timeout
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "soc_periph_defs.svh"

module soc_periph_tb
  import soc_bus_pkg::*;
  import soc_irq_pkg::*;
;

  typedef struct {
    string     name;
    logic      write;
    apb_addr_t addr;
    apb_data_t wdata;
    apb_strb_t strb;
    apb_data_t exp_rdata;
    logic      exp_err;
  } stim_t;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       psel_i;
  logic       penable_i;
  logic       pwrite_i;
  apb_addr_t  paddr_i;
  apb_data_t  pwdata_i;
  apb_strb_t  pstrb_i;
  apb_data_t  prdata_o;
  logic       pready_o;
  logic       pslverr_o;
  logic       rtc_i;
  logic [1:0] irq_ext_i;
  logic       timer_irq_o;
  logic       ipi_o;
  irq_word_u  irq_vec_o;

  stim_t stim_q[$];

  always #4 clk_i = ~clk_i;

  soc_periph_top soc_periph_top_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .psel_i      ( psel_i      ),
    .penable_i   ( penable_i   ),
    .pwrite_i    ( pwrite_i    ),
    .paddr_i     ( paddr_i     ),
    .pwdata_i    ( pwdata_i    ),
    .pstrb_i     ( pstrb_i     ),
    .prdata_o    ( prdata_o    ),
    .pready_o    ( pready_o    ),
    .pslverr_o   ( pslverr_o   ),
    .rtc_i       ( rtc_i       ),
    .irq_ext_i   ( irq_ext_i   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .irq_vec_o   ( irq_vec_o   )
  );

  bind soc_periph_top soc_periph_assertions soc_periph_assertions_inst (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .psel_i      ( psel_i      ),
    .penable_i   ( penable_i   ),
    .pwrite_i    ( pwrite_i    ),
    .prdata_i    ( prdata_o    ),
    .pready_i    ( pready_o    ),
    .pslverr_i   ( pslverr_o   ),
    .ipi_i       ( ipi_o       ),
    .timer_irq_i ( timer_irq_o )
  );

  // --------------------------------------------------------------------
  // failure and compare helpers
  // --------------------------------------------------------------------
  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_irq(input string name, input irq_word_u exp, input irq_word_u act);
    if (act.raw !== exp.raw) begin
      $display("FAILED %s: expected %h, actual %h", name, exp.raw, act.raw);
      abort_run();
    end
  endtask

  function automatic apb_addr_t clint_addr(input logic [15:0] ofs);
    return `CLINT_BASE + apb_addr_t'(ofs);
  endfunction

  function automatic apb_addr_t sram_addr(input int idx);
    return `SRAM_BASE + apb_addr_t'(idx * 4);
  endfunction

  // SRAM reads take one wait state, every other transfer none
  function automatic int exp_wait_states(input logic write, input apb_addr_t addr);
    if (!write && addr >= `SRAM_BASE && addr < `SRAM_BASE + `SRAM_WORDS * 4) begin
      return 1;
    end
    return 0;
  endfunction

  // --------------------------------------------------------------------
  // APB master
  // --------------------------------------------------------------------
  task automatic apb_xfer(input string name, input logic write, input apb_addr_t addr,
                          input apb_data_t wdata, input apb_strb_t strb,
                          output apb_data_t rdata, output logic err);
    int cycles;
    int exp_waits;
    exp_waits = exp_wait_states(write, addr);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    pstrb_i   <= write ? strb : '0;
    @(posedge clk_i);
    penable_i <= 1'b1;
    cycles = 0;
    // sampled mid-cycle, ahead of the completing edge
    @(negedge clk_i);
    while (!pready_o) begin
      cycles++;
      if (cycles > 16) begin
        $display("%s: no pready within 16 cycles for transfer to %h", name, addr);
        abort_run();
      end
      @(negedge clk_i);
    end
    if (cycles != exp_waits) begin
      $display("FAILED %s: expected %0d wait states, actual %0d", name, exp_waits, cycles);
      abort_run();
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic reg_write(input string name, input apb_addr_t addr, input apb_data_t data,
                           input apb_strb_t strb);
    apb_data_t rdata;
    logic      err;
    apb_xfer(name, 1'b1, addr, data, strb, rdata, err);
    check_err(name, 1'b0, err);
  endtask

  task automatic reg_read(input string name, input apb_addr_t addr, input apb_data_t exp);
    apb_data_t rdata;
    logic      err;
    apb_xfer(name, 1'b0, addr, '0, '0, rdata, err);
    check_err(name, 1'b0, err);
    check_data(name, exp, rdata);
  endtask

  task automatic add_entry(input string name, input logic write, input apb_addr_t addr,
                           input apb_data_t wdata, input apb_data_t exp_rdata,
                           input logic exp_err);
    stim_t s;
    s.name      = name;
    s.write     = write;
    s.addr      = addr;
    s.wdata     = wdata;
    s.strb      = 4'hf;
    s.exp_rdata = exp_rdata;
    s.exp_err   = exp_err;
    stim_q.push_back(s);
  endtask

  // --------------------------------------------------------------------
  // stimulus table: ROM, error region and CLINT register access
  // --------------------------------------------------------------------
  task automatic build_table();
    for (int i = 0; i < 16; i++) begin
      add_entry($sformatf("rom_rd_%0d", i), 1'b0, `ROM_BASE + apb_addr_t'(4 * i), '0,
                {`ROM_SIGNATURE, 16'(i)}, 1'b0);
    end
    add_entry("rom_wr", 1'b1, `ROM_BASE + 32'h4, 32'h0000_dead, '0, 1'b1);
    add_entry("unmapped_rd", 1'b0, 32'h4000_0000, '0, 32'h0, 1'b1);
    add_entry("unmapped_wr", 1'b1, 32'h1000_0000, 32'h1234_5678, '0, 1'b1);
    add_entry("mtime_lo_wr", 1'b1, clint_addr(`MTIME_LO_OFS), 32'h55, '0, 1'b1);
    add_entry("mip_wr", 1'b1, clint_addr(`MIP_OFS), 32'h8, '0, 1'b1);
    add_entry("clint_unknown_rd", 1'b0, clint_addr(16'h0100), '0, 32'h0, 1'b1);
    add_entry("mtimecmp_lo_wr", 1'b1, clint_addr(`MTIMECMP_LO_OFS), 32'h1234_5678, '0, 1'b0);
    add_entry("mtimecmp_lo_rd", 1'b0, clint_addr(`MTIMECMP_LO_OFS), '0, 32'h1234_5678, 1'b0);
    add_entry("mtimecmp_hi_rd", 1'b0, clint_addr(`MTIMECMP_HI_OFS), '0, 32'hffff_ffff, 1'b0);
    add_entry("msip_rd", 1'b0, clint_addr(`MSIP_OFS), '0, 32'h0, 1'b0);
    add_entry("mtime_hi_rd", 1'b0, clint_addr(`MTIME_HI_OFS), '0, 32'h0, 1'b0);
  endtask

  task automatic run_table();
    apb_data_t rdata;
    logic      err;
    foreach (stim_q[i]) begin
      apb_xfer(stim_q[i].name, stim_q[i].write, stim_q[i].addr, stim_q[i].wdata,
               stim_q[i].strb, rdata, err);
      check_err(stim_q[i].name, stim_q[i].exp_err, err);
      if (!stim_q[i].write) begin
        check_data(stim_q[i].name, stim_q[i].exp_rdata, rdata);
      end
    end
  endtask

  // random words against a model, then one partial-strobe write
  task automatic test_sram();
    apb_data_t model [int];
    apb_data_t wdata;
    apb_data_t merged;
    apb_strb_t strb;
    int        idx;
    for (int n = 0; n < 12; n++) begin
      idx   = $urandom_range(`SRAM_WORDS - 1, 0);
      wdata = $urandom();
      reg_write($sformatf("sram_wr_%0d", n), sram_addr(idx), wdata, 4'hf);
      model[idx] = wdata;
    end
    foreach (model[k]) begin
      reg_read($sformatf("sram_rd_%0d", k), sram_addr(k), model[k]);
    end
    void'(model.first(idx));
    wdata  = $urandom();
    strb   = 4'b0110;
    merged = model[idx];
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    reg_write("sram_partial_wr", sram_addr(idx), wdata, strb);
    reg_read("sram_partial_rd", sram_addr(idx), merged);
  endtask

  // external lines: bit 0 is meip, bit 1 is seip
  task automatic drive_ext(input logic [1:0] ext, input string name);
    irq_word_u exp;
    @(posedge clk_i);
    irq_ext_i <= ext;
    @(negedge clk_i);
    exp.raw         = '0;
    exp.fields.meip = ext[0];
    exp.fields.seip = ext[1];
    check_irq(name, exp, irq_vec_o);
    reg_read({name, "_mip"}, clint_addr(`MIP_OFS), exp.raw);
  endtask

  task automatic test_swi();
    irq_word_u exp;
    reg_write("msip_set", clint_addr(`MSIP_OFS), 32'h1, 4'hf);
    @(negedge clk_i);
    exp.raw         = '0;
    exp.fields.msip = 1'b1;
    check_err("ipi_set", 1'b1, ipi_o);
    check_irq("irq_vec_msip_set", exp, irq_vec_o);
    reg_read("mip_msip_set", clint_addr(`MIP_OFS), exp.raw);
    reg_write("msip_clr", clint_addr(`MSIP_OFS), 32'h0, 4'hf);
    @(negedge clk_i);
    exp.raw = '0;
    check_err("ipi_clr", 1'b0, ipi_o);
    check_irq("irq_vec_msip_clr", exp, irq_vec_o);
    reg_read("mip_msip_clr", clint_addr(`MIP_OFS), exp.raw);
    drive_ext(2'b11, "ext_both");
    drive_ext(2'b01, "ext_meip");
    drive_ext(2'b10, "ext_seip");
    drive_ext(2'b00, "ext_none");
  endtask

  // --------------------------------------------------------------------
  // timer
  // --------------------------------------------------------------------
  task automatic pulse_rtc();
    @(posedge clk_i);
    rtc_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    rtc_i <= 1'b0;
    repeat (3) @(posedge clk_i);
  endtask

  task automatic wait_timer_irq(input logic level, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (timer_irq_o !== level) begin
      if (cycles >= limit) begin
        $display("timer_irq_o did not reach %b within %0d cycles", level, limit);
        abort_run();
      end
      cycles++;
      @(negedge clk_i);
    end
  endtask

  task automatic test_timer();
    irq_word_u exp;
    reg_write("mtimecmp_lo_n", clint_addr(`MTIMECMP_LO_OFS), 32'd5, 4'hf);
    reg_write("mtimecmp_hi_0", clint_addr(`MTIMECMP_HI_OFS), 32'd0, 4'hf);
    for (int i = 0; i < 4; i++) begin
      pulse_rtc();
    end
    @(negedge clk_i);
    check_err("timer_irq_before_n", 1'b0, timer_irq_o);
    pulse_rtc();
    wait_timer_irq(1'b1, 32);
    reg_read("mtime_lo_n", clint_addr(`MTIME_LO_OFS), 32'd5);
    exp.raw         = '0;
    exp.fields.mtip = 1'b1;
    reg_read("mip_mtip", clint_addr(`MIP_OFS), exp.raw);
    reg_write("mtimecmp_hi_max", clint_addr(`MTIMECMP_HI_OFS), 32'hffff_ffff, 4'hf);
    wait_timer_irq(1'b0, 16);
  endtask

  initial begin
    void'($urandom(32'hacfb));
    rst_ni    = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    pstrb_i   = '0;
    rtc_i     = 1'b0;
    irq_ext_i = 2'b00;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_err("timer_irq_after_reset", 1'b0, timer_irq_o);
    check_err("ipi_after_reset", 1'b0, ipi_o);
    build_table();
    run_table();
    test_sram();
    test_swi();
    test_timer();
    repeat (2) @(posedge clk_i);
    if (soc_periph_top_inst.soc_periph_assertions_inst.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures during the run",
               soc_periph_top_inst.soc_periph_assertions_inst.fail_count);
      abort_run();
    end
  end

endmodule
